// ==== refgen_sine_table.svh ====
//--------------------
// Full-wave sine table, 64 entries
//--------------------

// One entry per 1/64 turn, peak 32767
localparam logic signed [refgen_pkg::SAMPLE_WIDTH-1:0] SINE_TABLE [2**refgen_pkg::LUT_BITS] = '{
    0, 3212, 6393, 9512, 12540, 15446, 18204, 20787,
    23170, 25329, 27245, 28898, 30273, 31356, 32137, 32609,
    32767, 32609, 32137, 31356, 30273, 28898, 27245, 25329,
    23170, 20787, 18204, 15446, 12540, 9512, 6393, 3212,
    0, -3212, -6393, -9512, -12540, -15446, -18204, -20787,
    -23170, -25329, -27245, -28898, -30273, -31356, -32137, -32609,
    -32767, -32609, -32137, -31356, -30273, -28898, -27245, -25329,
    -23170, -20787, -18204, -15446, -12540, -9512, -6393, -3212
};

// ==== refgen_pkg.sv ====
//--------------------
// Widths, register offsets and reset values of the reference generator
//--------------------
package refgen_pkg;

    // One full turn of the angle spans the whole phase word
    localparam int PHASE_WIDTH = 32;
    localparam int SAMPLE_WIDTH = 16;
    // Top phase bits used as table index
    localparam int LUT_BITS = 6;

    // APB bus widths
    localparam int ADDR_WIDTH = 12;
    localparam int DATA_WIDTH = 32;

    // Register byte offsets
    localparam logic [ADDR_WIDTH-1:0] ADDR_MODE = 12'h000;
    localparam logic [ADDR_WIDTH-1:0] ADDR_ADVANCE = 12'h004;
    localparam logic [ADDR_WIDTH-1:0] ADDR_PERIOD = 12'h008;

    // Register reset values
    localparam logic [PHASE_WIDTH-1:0] RESET_ADVANCE = 32'd2;
    localparam logic [DATA_WIDTH-1:0] RESET_PERIOD = 32'd100;

endpackage

// ==== refgen_apb_regs.sv ====
//--------------------
// APB control registers: mode, phase advance, sampling period
//--------------------
`timescale 1ns/10ps

module refgen_apb_regs (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [refgen_pkg::ADDR_WIDTH-1:0]   paddr,
    input  logic [refgen_pkg::DATA_WIDTH-1:0]   pwdata,
    output logic [refgen_pkg::DATA_WIDTH-1:0]   prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                emulation_mode,
    output logic [refgen_pkg::PHASE_WIDTH-1:0]  phase_advance,
    output logic [refgen_pkg::DATA_WIDTH-1:0]   sampling_period
);

    logic write_access;
    logic write_wait;
    logic addr_hit;

    assign write_access = psel && penable && pwrite;

    assign addr_hit = (paddr == refgen_pkg::ADDR_MODE)
                   || (paddr == refgen_pkg::ADDR_ADVANCE)
                   || (paddr == refgen_pkg::ADDR_PERIOD);

    // First access cycle of a write is the wait state
    assign pready = !(write_access && !write_wait);

    // Error only in the completing cycle
    assign pslverr = psel && penable && pready && !addr_hit;

    // Access flag, set during the second access cycle of a write
    always_ff @(posedge clock) begin
        if (!reset) begin
            write_wait <= 1'b0;
        end else if (write_access) begin
            write_wait <= !write_wait;
        end else begin
            write_wait <= 1'b0;
        end
    end

    // Registers take the write data at the end of the wait state
    always_ff @(posedge clock) begin
        if (!reset) begin
            emulation_mode <= 1'b0;
            phase_advance <= refgen_pkg::RESET_ADVANCE;
            sampling_period <= refgen_pkg::RESET_PERIOD;
        end else if (write_access && !write_wait) begin
            case (paddr)
                refgen_pkg::ADDR_MODE: emulation_mode <= pwdata[0];
                refgen_pkg::ADDR_ADVANCE: phase_advance <= pwdata[refgen_pkg::PHASE_WIDTH-1:0];
                refgen_pkg::ADDR_PERIOD: sampling_period <= pwdata;
                default: begin
                end
            endcase
        end
    end

    // Read mux, unmapped offsets read zero
    always_comb begin
        case (paddr)
            refgen_pkg::ADDR_MODE:
                prdata = {{(refgen_pkg::DATA_WIDTH-1){1'b0}}, emulation_mode};
            refgen_pkg::ADDR_ADVANCE:
                prdata = refgen_pkg::DATA_WIDTH'(phase_advance);
            refgen_pkg::ADDR_PERIOD:
                prdata = sampling_period;
            default:
                prdata = '0;
        endcase
    end

endmodule

// ==== refgen_timebase.sv ====
//--------------------
// Sampling period counter and sample tick
//--------------------
`timescale 1ns/10ps

module refgen_timebase (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [refgen_pkg::DATA_WIDTH-1:0]  sampling_period,
    output logic                               tick
);

    logic [refgen_pkg::DATA_WIDTH-1:0] count;

    // Down counter, a new period is only picked up on reload
    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
            tick <= 1'b0;
        end else if (count == '0) begin
            tick <= 1'b1;
            // Periods of 0 and 1 both tick every cycle
            if (sampling_period <= 1) begin
                count <= '0;
            end else begin
                count <= sampling_period - 1'b1;
            end
        end else begin
            tick <= 1'b0;
            count <= count - 1'b1;
        end
    end

endmodule

// ==== refgen_phase_acc.sv ====
//--------------------
// Phase accumulator with emulation or external angle
//--------------------
`timescale 1ns/10ps

module refgen_phase_acc (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                tick,
    input  logic                                emulation_mode,
    input  logic [refgen_pkg::PHASE_WIDTH-1:0]  phase_advance,
    input  logic [refgen_pkg::PHASE_WIDTH-1:0]  ext_phase,
    output logic [refgen_pkg::PHASE_WIDTH-1:0]  phase,
    output logic                                phase_valid
);

    logic [refgen_pkg::PHASE_WIDTH-1:0] next_phase;

    // Wraps modulo one turn through the natural overflow
    always_comb begin
        if (emulation_mode) begin
            next_phase = phase + phase_advance;
        end else begin
            next_phase = ext_phase;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            phase <= '0;
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= tick;
            if (tick) begin
                phase <= next_phase;
            end
        end
    end

endmodule

// ==== refgen_phase_split.sv ====
//--------------------
// Splits one phase into N equally spaced angles
//--------------------
`timescale 1ns/10ps

module refgen_phase_split #(
    parameter int N_PHASES = 3
) (
    input  logic                                         clock,
    input  logic                                         reset,
    input  logic [refgen_pkg::PHASE_WIDTH-1:0]           phase,
    input  logic                                         phase_valid,
    output logic [N_PHASES*refgen_pkg::PHASE_WIDTH-1:0]  angles,
    output logic                                         angles_valid
);

    localparam int PW = refgen_pkg::PHASE_WIDTH;

    // One turn divided by the phase count, truncated
    localparam logic [PW-1:0] PHASE_OFFSET = PW'((64'd1 << PW) / N_PHASES);

    always_ff @(posedge clock) begin
        if (!reset) begin
            angles_valid <= 1'b0;
        end else begin
            angles_valid <= phase_valid;
        end
    end

    // Angle k sits k offsets ahead of the input phase
    always_ff @(posedge clock) begin
        for (int k = 0; k < N_PHASES; k++) begin
            angles[k*PW +: PW] <= phase + PW'(k) * PHASE_OFFSET;
        end
    end

endmodule

// ==== refgen_sine_lut.sv ====
//--------------------
// Sine lookup for every phase
//--------------------
`timescale 1ns/10ps

module refgen_sine_lut #(
    parameter int N_PHASES = 3
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic [N_PHASES*refgen_pkg::PHASE_WIDTH-1:0]   angles,
    input  logic                                          angles_valid,
    output logic [N_PHASES*refgen_pkg::SAMPLE_WIDTH-1:0]  references,
    output logic                                          references_valid
);

    `include "refgen_sine_table.svh"

    localparam int PW = refgen_pkg::PHASE_WIDTH;
    localparam int SW = refgen_pkg::SAMPLE_WIDTH;

    logic [refgen_pkg::LUT_BITS-1:0] lut_index [N_PHASES];

    // Index from the top bits of each angle
    always_comb begin
        for (int k = 0; k < N_PHASES; k++) begin
            lut_index[k] = angles[k*PW + PW - 1 -: refgen_pkg::LUT_BITS];
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            references_valid <= 1'b0;
        end else begin
            references_valid <= angles_valid;
        end
    end

    always_ff @(posedge clock) begin
        for (int k = 0; k < N_PHASES; k++) begin
            references[k*SW +: SW] <= SINE_TABLE[lut_index[k]];
        end
    end

endmodule

// ==== refgen_top.sv ====
//--------------------
// Multiphase reference generator top level
//--------------------
`timescale 1ns/10ps

module refgen_top #(
    parameter int N_PHASES = 3
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          psel,
    input  logic                                          penable,
    input  logic                                          pwrite,
    input  logic [refgen_pkg::ADDR_WIDTH-1:0]             paddr,
    input  logic [refgen_pkg::DATA_WIDTH-1:0]             pwdata,
    output logic [refgen_pkg::DATA_WIDTH-1:0]             prdata,
    output logic                                          pready,
    output logic                                          pslverr,
    input  logic [refgen_pkg::PHASE_WIDTH-1:0]            ext_phase,
    output logic [N_PHASES*refgen_pkg::SAMPLE_WIDTH-1:0]  references,
    output logic                                          references_valid
);

    logic                                        emulation_mode;
    logic [refgen_pkg::PHASE_WIDTH-1:0]          phase_advance;
    logic [refgen_pkg::DATA_WIDTH-1:0]           sampling_period;
    logic                                        tick;
    logic [refgen_pkg::PHASE_WIDTH-1:0]          phase;
    logic                                        phase_valid;
    logic [N_PHASES*refgen_pkg::PHASE_WIDTH-1:0] angles;
    logic                                        angles_valid;

    refgen_apb_regs i_refgen_apb_regs (
        .clock(clock),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .emulation_mode(emulation_mode),
        .phase_advance(phase_advance),
        .sampling_period(sampling_period)
    );

    refgen_timebase i_refgen_timebase (
        .clock(clock),
        .reset(reset),
        .sampling_period(sampling_period),
        .tick(tick)
    );

    refgen_phase_acc i_refgen_phase_acc (
        .clock(clock),
        .reset(reset),
        .tick(tick),
        .emulation_mode(emulation_mode),
        .phase_advance(phase_advance),
        .ext_phase(ext_phase),
        .phase(phase),
        .phase_valid(phase_valid)
    );

    refgen_phase_split #(
        .N_PHASES(N_PHASES)
    ) i_refgen_phase_split (
        .clock(clock),
        .reset(reset),
        .phase(phase),
        .phase_valid(phase_valid),
        .angles(angles),
        .angles_valid(angles_valid)
    );

    refgen_sine_lut #(
        .N_PHASES(N_PHASES)
    ) i_refgen_sine_lut (
        .clock(clock),
        .reset(reset),
        .angles(angles),
        .angles_valid(angles_valid),
        .references(references),
        .references_valid(references_valid)
    );

endmodule

// ==== refgen_properties.sv ====
//--------------------
// APB and pipeline assertions, bound to refgen_top
//--------------------
`timescale 1ns/10ps

module refgen_properties (
    input logic clock,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic tick,
    input logic references_valid
);

    penable_needs_psel: assert property (
        @(posedge clock) disable iff (!reset) $rose(penable) |-> psel
    ) else $error("penable rose without psel");

    // Three register stages between tick and output
    valid_follows_tick: assert property (
        @(posedge clock) disable iff (!reset) references_valid == $past(tick, 3)
    ) else $error("references_valid not 3 cycles after tick");

    // A write wait state lasts a single access cycle
    wait_state_one_cycle: assert property (
        @(posedge clock) disable iff (!reset) (psel && penable && !pready) |=> pready
    ) else $error("pready stayed low for more than one access cycle");

endmodule

bind refgen_top refgen_properties i_refgen_properties (
    .clock(clock),
    .reset(reset),
    .psel(psel),
    .penable(penable),
    .pready(pready),
    .tick(tick),
    .references_valid(references_valid)
);

// ==== refgen_tb.sv ====
//--------------------
// Testbench: APB tasks, random stimulus, phase model and report
//--------------------
`timescale 1ns/10ps

module refgen_tb;

    `include "refgen_sine_table.svh"

    localparam int N_PHASES = 3;
    localparam int SW = refgen_pkg::SAMPLE_WIDTH;
    localparam int MAX_CYCLES = 20000;
    // One third of a turn, truncated
    localparam logic [31:0] TURN_OFFSET = 32'd1431655765;

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic [31:0] ext_phase;
    logic [N_PHASES*SW-1:0] references;
    logic references_valid;

    integer seed = 7;
    int errors = 0;
    int checks = 0;
    int error_mark = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int samples_checked = 0;
    int cycle_count = 0;
    int gap;
    logic err;
    logic [11:0] addr;
    logic [31:0] value;
    logic [31:0] data;
    logic [31:0] period;

    // Register copies and a three cycle history of the values seen at each tick
    logic shadow_mode = 1'b0;
    logic [31:0] shadow_advance = refgen_pkg::RESET_ADVANCE;
    logic hist_mode [3] = '{1'b0, 1'b0, 1'b0};
    logic [31:0] hist_advance [3] = '{32'd0, 32'd0, 32'd0};
    logic [31:0] hist_ext [3] = '{32'd0, 32'd0, 32'd0};
    logic [31:0] model_phase = 32'd0;
    logic [31:0] angle;
    logic signed [SW-1:0] expected;

    refgen_top #(.N_PHASES(N_PHASES)) i_refgen_top (
        .clock(clock), .reset(reset), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr), .ext_phase(ext_phase), .references(references),
        .references_valid(references_valid)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic apb_write(input logic [11:0] wr_addr, input logic [31:0] wr_data,
                             output logic wr_err);
        int waits;
        @(posedge clock);
        psel <= 1'b1;
        pwrite <= 1'b1;
        paddr <= wr_addr;
        pwdata <= wr_data;
        @(posedge clock);
        penable <= 1'b1;
        waits = 0;
        @(negedge clock);
        while (!pready) begin
            waits++;
            @(negedge clock);
        end
        wr_err = pslverr;
        // Register already holds the new value in this cycle
        case (wr_addr)
            refgen_pkg::ADDR_MODE: shadow_mode = wr_data[0];
            refgen_pkg::ADDR_ADVANCE: shadow_advance = wr_data;
            default: begin
            end
        endcase
        check_value("write wait cycles", 32'(waits), 32'd1);
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [11:0] rd_addr, output logic [31:0] rd_data,
                            output logic rd_err);
        int waits;
        @(posedge clock);
        psel <= 1'b1;
        pwrite <= 1'b0;
        paddr <= rd_addr;
        @(posedge clock);
        penable <= 1'b1;
        waits = 0;
        @(negedge clock);
        while (!pready) begin
            waits++;
            @(negedge clock);
        end
        rd_data = prdata;
        rd_err = pslverr;
        check_value("read wait cycles", 32'(waits), 32'd0);
        @(posedge clock);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_read(input logic [11:0] rw_addr, input logic [31:0] rw_data,
                              input logic [31:0] want);
        logic rw_err;
        logic [31:0] got;
        apb_write(rw_addr, rw_data, rw_err);
        check_value("pslverr", {31'd0, rw_err}, 32'd0);
        apb_read(rw_addr, got, rw_err);
        check_value("prdata", got, want);
    endtask

    // Counts cycles up to the next references_valid pulse
    task automatic wait_sample(output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!references_valid);
    endtask

    task automatic finish_test(input string name);
        if (errors == error_mark) begin
            tests_passed++;
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: fail with %0d errors", name, errors - error_mark);
        end
        error_mark = errors;
    endtask

    always @(posedge clock) begin
        for (int i = 2; i > 0; i--) begin
            hist_mode[i] = hist_mode[i-1];
            hist_advance[i] = hist_advance[i-1];
            hist_ext[i] = hist_ext[i-1];
        end
        hist_mode[0] = shadow_mode;
        hist_advance[0] = shadow_advance;
        hist_ext[0] = ext_phase;
    end

    // Model of the phase at the tick three cycles back, checked on every sample
    always @(negedge clock) begin
        if (reset && references_valid) begin
            if (hist_mode[2]) begin
                model_phase = model_phase + hist_advance[2];
            end else begin
                model_phase = hist_ext[2];
            end
            for (int k = 0; k < N_PHASES; k++) begin
                angle = model_phase + 32'(k) * TURN_OFFSET;
                expected = SINE_TABLE[angle[31 -: refgen_pkg::LUT_BITS]];
                check_value($sformatf("references[%0d]", k),
                            {16'd0, references[k*SW +: SW]}, {16'd0, expected});
            end
            samples_checked++;
        end
    end

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 12'd0;
        pwdata = 32'd0;
        ext_phase = 32'd0;
        repeat (4) @(posedge clock);
        reset <= 1'b1;

        apb_read(refgen_pkg::ADDR_MODE, data, err);
        check_value("mode after reset", data, 32'd0);
        apb_read(refgen_pkg::ADDR_ADVANCE, data, err);
        check_value("advance after reset", data, 32'd2);
        apb_read(refgen_pkg::ADDR_PERIOD, data, err);
        check_value("period after reset", data, 32'd100);
        repeat (3) begin
            value = $random(seed);
            write_read(refgen_pkg::ADDR_MODE, value, {31'd0, value[0]});
            value = $random(seed);
            write_read(refgen_pkg::ADDR_ADVANCE, value, value);
            period = 32'd2 + ({$random(seed)} % 32'd99);
            write_read(refgen_pkg::ADDR_PERIOD, period, period);
        end
        finish_test("register reset and read back");

        repeat (4) begin
            value = $random(seed);
            addr = value[11:0];
            if (addr == refgen_pkg::ADDR_MODE || addr == refgen_pkg::ADDR_ADVANCE
                    || addr == refgen_pkg::ADDR_PERIOD) begin
                addr = addr + 12'h100;
            end
            apb_write(addr, $random(seed), err);
            check_value("pslverr on write", {31'd0, err}, 32'd1);
            apb_read(addr, data, err);
            check_value("pslverr on read", {31'd0, err}, 32'd1);
            check_value("unmapped prdata", data, 32'd0);
        end
        apb_read(refgen_pkg::ADDR_MODE, data, err);
        check_value("mode", data, {31'd0, shadow_mode});
        apb_read(refgen_pkg::ADDR_ADVANCE, data, err);
        check_value("advance", data, shadow_advance);
        apb_read(refgen_pkg::ADDR_PERIOD, data, err);
        check_value("period", data, period);
        finish_test("unmapped offsets");

        period = 32'd2 + ({$random(seed)} % 32'd39);
        write_read(refgen_pkg::ADDR_PERIOD, period, period);
        // New period starts after the old count wraps
        repeat (3) wait_sample(gap);
        repeat (5) begin
            wait_sample(gap);
            check_value("sample interval", 32'(gap), period);
        end
        finish_test("sampling period");

        write_read(refgen_pkg::ADDR_MODE, 32'd1, 32'd1);
        value = $random(seed);
        write_read(refgen_pkg::ADDR_ADVANCE, value, value);
        repeat (20) wait_sample(gap);
        finish_test("emulation mode");

        write_read(refgen_pkg::ADDR_MODE, 32'd0, 32'd0);
        repeat (4) begin
            @(posedge clock);
            ext_phase <= $random(seed);
            repeat (4) wait_sample(gap);
        end
        finish_test("external mode");

        write_read(refgen_pkg::ADDR_MODE, 32'd1, 32'd1);
        repeat (5) wait_sample(gap);
        @(posedge clock);
        ext_phase <= $random(seed);
        write_read(refgen_pkg::ADDR_MODE, 32'd0, 32'd0);
        repeat (5) wait_sample(gap);
        finish_test("mode switch");

        if (samples_checked == 0) begin
            $display("no reference samples were checked");
            errors++;
        end
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checks, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
refgen_pkg.sv
refgen_apb_regs.sv
refgen_timebase.sv
refgen_phase_acc.sv
refgen_phase_split.sv
refgen_sine_lut.sv
refgen_top.sv
refgen_properties.sv
refgen_tb.sv

// ==== Makefile ====
SIM       ?= verilator
TOP       ?= refgen_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing --assert --timescale 1ns/10ps
PASS_TEXT := Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run $(TOP) and log to $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
